//--- source/noc_route_pkg.sv
/*
 * Port numbering and port vector types shared by the mesh router route logic.
 * Also holds the helpers that move between full one-hot vectors and the
 * 4-bit encoded form, where one port is left out of the vector.
 */
package noc_route_pkg;

    localparam int PORT_COUNT = 5;  // local plus four mesh directions

    localparam int PORT_LOCAL = 0;
    localparam int PORT_EAST  = 1;  // x + 1
    localparam int PORT_NORTH = 2;  // y - 1
    localparam int PORT_WEST  = 3;  // x - 1
    localparam int PORT_SOUTH = 4;  // y + 1

    typedef logic [PORT_COUNT-1:0] port_onehot_t;
    typedef logic [PORT_COUNT-2:0] port_code_t;

    // bits below the removed port keep their place, bits above shift down by one
    function automatic port_code_t port_remove(port_onehot_t full, port_onehot_t sel);
        port_onehot_t below;
        port_onehot_t merged;
        below  = sel - 1'b1;  // ones under the removed bit
        merged = (full & below) | ((full >> 1) & ~below);
        return port_code_t'(merged);
    endfunction

    // inverse of port_remove; the removed position comes back as zero
    function automatic port_onehot_t port_insert(port_code_t code, port_onehot_t sel);
        port_onehot_t ext;
        port_onehot_t below;
        ext   = port_onehot_t'(code);
        below = sel - 1'b1;
        return (ext & below) | ((ext << 1) & ~below & ~sel);
    endfunction

endpackage

//--- source/route_input_stage.sv
/*
 * First pipeline stage of the look-ahead route unit.
 * Captures each valid request and rebuilds the full one-hot output port
 * from the encoded port, which leaves out this router's input SW_LOC.
 */
module route_input_stage #(
    parameter int NX = 4,
    parameter int NY = 4,
    parameter int SW_LOC = 0,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  logic [XW-1:0]               dest_x,
    input  logic [YW-1:0]               dest_y,
    input  noc_route_pkg::port_code_t   in_port,
    output logic                        s1_valid,
    output logic [XW-1:0]               s1_dest_x,
    output logic [YW-1:0]               s1_dest_y,
    output noc_route_pkg::port_onehot_t s1_port
);

    // one-hot mark of the port this stage serves
    localparam noc_route_pkg::port_onehot_t SW_SEL =
        noc_route_pkg::port_onehot_t'(1) << SW_LOC;

    noc_route_pkg::port_onehot_t full_port;

    // a flit never turns back through its own input, so that bit is zero
    always_comb begin
        full_port = noc_route_pkg::port_insert(in_port, SW_SEL);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s1_dest_x <= '0;
            s1_dest_y <= '0;
            s1_port   <= '0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin  // payload only moves with a request
                s1_dest_x <= dest_x;
                s1_dest_y <= dest_y;
                s1_port   <= full_port;
            end
        end
    end

    // upstream switch allocator must hand over exactly one port per head flit
    a_in_port_onehot : assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> $onehot(in_port)
    ) else $error("in_port is not one-hot on a valid request");

endmodule

//--- source/next_hop_predictor.sv
/*
 * Predicts the neighbour a flit reaches through its chosen output port and
 * the port it enters that neighbour on. Purely combinational.
 */
module next_hop_predictor #(
    parameter int NX = 4,
    parameter int NY = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  noc_route_pkg::port_onehot_t cur_port,
    input  logic [XW-1:0]               cur_x,
    input  logic [YW-1:0]               cur_y,
    output logic [XW-1:0]               next_x,
    output logic [YW-1:0]               next_y,
    output noc_route_pkg::port_onehot_t recv_port
);

    localparam logic [XW-1:0] LAST_X = XW'(NX - 1);
    localparam logic [YW-1:0] LAST_Y = YW'(NY - 1);

    // mesh edges hold the address, there is no wrap-around link
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        if (cur_port[noc_route_pkg::PORT_EAST]) begin
            if (cur_x != LAST_X) begin
                next_x = cur_x + 1'b1;
            end
        end else if (cur_port[noc_route_pkg::PORT_NORTH]) begin
            if (cur_y != '0) begin
                next_y = cur_y - 1'b1;  // north is towards row 0
            end
        end else if (cur_port[noc_route_pkg::PORT_WEST]) begin
            if (cur_x != '0) begin
                next_x = cur_x - 1'b1;
            end
        end else if (cur_port[noc_route_pkg::PORT_SOUTH]) begin
            if (cur_y != LAST_Y) begin
                next_y = cur_y + 1'b1;
            end
        end
    end

    // leaving east means arriving on the neighbour's west side, and so on
    always_comb begin
        recv_port = '0;
        recv_port[noc_route_pkg::PORT_LOCAL] = cur_port[noc_route_pkg::PORT_LOCAL];
        recv_port[noc_route_pkg::PORT_WEST]  = cur_port[noc_route_pkg::PORT_EAST];
        recv_port[noc_route_pkg::PORT_EAST]  = cur_port[noc_route_pkg::PORT_WEST];
        recv_port[noc_route_pkg::PORT_SOUTH] = cur_port[noc_route_pkg::PORT_NORTH];
        recv_port[noc_route_pkg::PORT_NORTH] = cur_port[noc_route_pkg::PORT_SOUTH];
    end

endmodule

//--- source/lookahead_port_stage.sv
/*
 * Second pipeline stage. Runs XY routing as the next router would, encodes
 * the result relative to that router's receive port and registers it.
 * An ejecting flit (current port local) gets an all-zero look-ahead port.
 */
module lookahead_port_stage #(
    parameter int NX = 4,
    parameter int NY = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s1_valid,
    input  logic [XW-1:0]               next_x,
    input  logic [YW-1:0]               next_y,
    input  noc_route_pkg::port_onehot_t recv_port,
    input  logic [XW-1:0]               s1_dest_x,
    input  logic [YW-1:0]               s1_dest_y,
    output logic                        out_valid,
    output noc_route_pkg::port_code_t   lk_port
);

    noc_route_pkg::port_onehot_t xy_port;
    noc_route_pkg::port_code_t   lk_next;

    // dimension order: finish x before touching y
    always_comb begin
        xy_port = '0;
        if (s1_dest_x > next_x) begin
            xy_port[noc_route_pkg::PORT_EAST] = 1'b1;
        end else if (s1_dest_x < next_x) begin
            xy_port[noc_route_pkg::PORT_WEST] = 1'b1;
        end else if (s1_dest_y < next_y) begin
            xy_port[noc_route_pkg::PORT_NORTH] = 1'b1;
        end else if (s1_dest_y > next_y) begin
            xy_port[noc_route_pkg::PORT_SOUTH] = 1'b1;
        end else begin
            xy_port[noc_route_pkg::PORT_LOCAL] = 1'b1;  // arrived
        end
    end

    // encode relative to the neighbour's input side
    always_comb begin
        if (recv_port[noc_route_pkg::PORT_LOCAL]) begin
            lk_next = '0;  // flit ejects here, neighbour not involved
        end else begin
            lk_next = noc_route_pkg::port_remove(xy_port, recv_port);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            lk_port   <= '0;
        end else begin
            out_valid <= s1_valid;
            lk_port   <= s1_valid ? lk_next : '0;  // idle cycles read as zero
        end
    end

    // the removal step must never turn one port into several
    a_lk_port_onehot0 : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(lk_port)
    ) else $error("lk_port has more than one bit set");

    // predictor and XY must agree: a flit never routes back out its receive side
    a_no_u_turn : assert property (
        @(posedge clk) disable iff (reset)
        (s1_valid && !recv_port[noc_route_pkg::PORT_LOCAL]) |-> ((xy_port & recv_port) == '0)
    ) else $error("look-ahead port points back to the receive port");

endmodule

//--- source/lookahead_route_top.sv
/*
 * Look-ahead XY route computation for one mesh router input port.
 * Two register stages: a request accepted on one edge shows up on
 * out_valid/lk_port after the next edge. No stall, one request per cycle.
 */
module lookahead_route_top #(
    parameter int NX = 4,
    parameter int NY = 4,
    parameter int SW_LOC = noc_route_pkg::PORT_LOCAL,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  logic [XW-1:0]             cur_x,     // this router's address
    input  logic [YW-1:0]             cur_y,
    input  logic [XW-1:0]             dest_x,
    input  logic [YW-1:0]             dest_y,
    input  noc_route_pkg::port_code_t in_port,   // relative to SW_LOC
    output logic                      out_valid,
    output noc_route_pkg::port_code_t lk_port    // relative to next router's input
);

    logic                        s1_valid;
    logic [XW-1:0]               s1_dest_x;
    logic [YW-1:0]               s1_dest_y;
    noc_route_pkg::port_onehot_t s1_port;
    logic [XW-1:0]               next_x;
    logic [YW-1:0]               next_y;
    noc_route_pkg::port_onehot_t recv_port;

    route_input_stage #(
        .NX     (NX),
        .NY     (NY),
        .SW_LOC (SW_LOC)
    ) i_input_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .in_port   (in_port),
        .s1_valid  (s1_valid),
        .s1_dest_x (s1_dest_x),
        .s1_dest_y (s1_dest_y),
        .s1_port   (s1_port)
    );

    next_hop_predictor #(
        .NX (NX),
        .NY (NY)
    ) i_predictor (
        .cur_port  (s1_port),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .next_x    (next_x),
        .next_y    (next_y),
        .recv_port (recv_port)
    );

    lookahead_port_stage #(
        .NX (NX),
        .NY (NY)
    ) i_port_stage (
        .clk       (clk),
        .reset     (reset),
        .s1_valid  (s1_valid),
        .next_x    (next_x),
        .next_y    (next_y),
        .recv_port (recv_port),
        .s1_dest_x (s1_dest_x),
        .s1_dest_y (s1_dest_y),
        .out_valid (out_valid),
        .lk_port   (lk_port)
    );

endmodule

//--- testbench/route_ref_model.svh
/*
 * Reference model for the look-ahead XY route unit, included by the testbench.
 * Works on plain port indices and builds the 4-bit encoded vectors from them.
 */
`ifndef ROUTE_REF_MODEL_SVH
`define ROUTE_REF_MODEL_SVH

// dimension order, x settled before y
function automatic int xy_route(int cx, int cy, int dx, int dy);
    int port;
    if (dx > cx) begin
        port = noc_route_pkg::PORT_EAST;
    end else if (dx < cx) begin
        port = noc_route_pkg::PORT_WEST;
    end else if (dy < cy) begin
        port = noc_route_pkg::PORT_NORTH;  // north is row 0 side
    end else if (dy > cy) begin
        port = noc_route_pkg::PORT_SOUTH;
    end else begin
        port = noc_route_pkg::PORT_LOCAL;
    end
    return port;
endfunction

// side of the neighbour a flit arrives on
function automatic int opposite_port(int port);
    case (port)
        noc_route_pkg::PORT_EAST:  return noc_route_pkg::PORT_WEST;
        noc_route_pkg::PORT_WEST:  return noc_route_pkg::PORT_EAST;
        noc_route_pkg::PORT_NORTH: return noc_route_pkg::PORT_SOUTH;
        noc_route_pkg::PORT_SOUTH: return noc_route_pkg::PORT_NORTH;
        default:                   return noc_route_pkg::PORT_LOCAL;
    endcase
endfunction

// encode one port with the removed port left out of the vector
function automatic noc_route_pkg::port_code_t drop_port(int port, int removed);
    noc_route_pkg::port_code_t code;
    code = '0;
    if (port < removed) begin
        code = noc_route_pkg::port_code_t'(1 << port);
    end else if (port > removed) begin
        code = noc_route_pkg::port_code_t'(1 << (port - 1));  // shifted down one place
    end
    return code;
endfunction

// port the flit takes at the next router, relative to its receive side
function automatic noc_route_pkg::port_code_t expected_lk_port(
    int cx, int cy, int dx, int dy, int cur_port, int size_x, int size_y);
    int nx;
    int ny;
    int next_port;
    if (cur_port == noc_route_pkg::PORT_LOCAL) begin
        return '0;  // ejects here
    end
    nx = cx;
    ny = cy;
    case (cur_port)
        noc_route_pkg::PORT_EAST:  if (cx < size_x - 1) nx = cx + 1;
        noc_route_pkg::PORT_WEST:  if (cx > 0) nx = cx - 1;
        noc_route_pkg::PORT_NORTH: if (cy > 0) ny = cy - 1;
        noc_route_pkg::PORT_SOUTH: if (cy < size_y - 1) ny = cy + 1;
        default: ;
    endcase
    next_port = xy_route(nx, ny, dx, dy);
    return drop_port(next_port, opposite_port(cur_port));
endfunction

`endif

//--- testbench/tb_lookahead_route.sv
/*
 * Testbench for the look-ahead route unit on a 4x4 mesh, input port west.
 * Drives random, back-to-back, ejecting, gapped and mesh corner requests
 * and checks each result and its timing against the reference model.
 */
module tb_lookahead_route;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MESH_NX = 4;
    localparam int MESH_NY = 4;
    localparam int SW_LOC = noc_route_pkg::PORT_WEST;
    localparam int XW = $clog2(MESH_NX);
    localparam int YW = $clog2(MESH_NY);
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 20;
    localparam int RANDOM_COUNT = 120;
    localparam int BURST_COUNT = 64;
    localparam int LOCAL_COUNT = 16;
    localparam int GAP_COUNT = 64;
    localparam int CORNER_MAX = 24;  // four corners, six edge destinations each
    localparam int NUM_VECTORS = RANDOM_COUNT + BURST_COUNT + LOCAL_COUNT + GAP_COUNT
                                 + CORNER_MAX;
    localparam int TIMEOUT_FACTOR = 4;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * TIMEOUT_FACTOR + RESET_CYCLES;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    logic [XW-1:0]             cur_x;
    logic [YW-1:0]             cur_y;
    logic [XW-1:0]             dest_x;
    logic [YW-1:0]             dest_y;
    noc_route_pkg::port_code_t in_port;
    logic                      out_valid;
    noc_route_pkg::port_code_t lk_port;

    noc_route_pkg::port_code_t exp_q[$];  // expected lk_port, in request order
    string                     name_q[$];
    int router_x = 0;
    int router_y = 0;
    int check_count = 0;
    int mismatch_count = 0;
    int other_count = 0;
    int sent_count = 0;
    int recv_count = 0;
    logic hist_accept;  // request seen before the accepting edge
    logic hist_stage;   // request sitting in stage one

    `include "route_ref_model.svh"

    lookahead_route_top #(
        .NX     (MESH_NX),
        .NY     (MESH_NY),
        .SW_LOC (SW_LOC)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .in_port   (in_port),
        .out_valid (out_valid),
        .lk_port   (lk_port)
    );

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic print_summary();
        $display("checks %0d, mismatches %0d, other errors %0d, sent %0d, received %0d",
                 check_count, mismatch_count, other_count, sent_count, recv_count);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // the router address may only change once the last request left stage one
    task automatic move_router(input int cx, input int cy);
        idle_cycle();
        router_x = cx;
        router_y = cy;
    endtask

    task automatic move_router_random();
        move_router($urandom_range(MESH_NX - 1, 0), $urandom_range(MESH_NY - 1, 0));
    endtask

    // a flit that came in west can not be routed back out west
    task automatic pick_dest(output int dx, output int dy);
        do begin
            dx = $urandom_range(MESH_NX - 1, 0);
            dy = $urandom_range(MESH_NY - 1, 0);
        end while (xy_route(router_x, router_y, dx, dy) == SW_LOC);
    endtask

    task automatic send_request(input string name, input int dx, input int dy);
        int port;
        port = xy_route(router_x, router_y, dx, dy);
        @(posedge clk);
        in_valid <= 1'b1;
        cur_x    <= XW'(router_x);
        cur_y    <= YW'(router_y);
        dest_x   <= XW'(dx);
        dest_y   <= YW'(dy);
        in_port  <= drop_port(port, SW_LOC);
        exp_q.push_back(expected_lk_port(router_x, router_y, dx, dy, port,
                                         MESH_NX, MESH_NY));
        name_q.push_back(name);
        sent_count++;
    endtask

    // outputs sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        noc_route_pkg::port_code_t expected_port;
        string                     expected_name;
        if (reset) begin
            check_value("reset_idle", 32'd0, 32'(out_valid));
            check_value("reset_idle", 32'd0, 32'(lk_port));
            hist_accept = 1'b0;
            hist_stage  = 1'b0;
        end else begin
            check_value("valid_timing", 32'(hist_stage), 32'(out_valid));
            hist_stage  = hist_accept;
            hist_accept = in_valid;  // taken on the coming rising edge
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("ERROR: a result came out with no request outstanding at %0t",
                             $time);
                end else begin
                    expected_port = exp_q.pop_front();
                    expected_name = name_q.pop_front();
                    recv_count++;
                    check_value(expected_name, 32'(expected_port), 32'(lk_port));
                end
            end else begin
                check_value("idle_zero", 32'd0, 32'(lk_port));
            end
        end
    end

    initial begin
        int dx;
        int dy;
        int gap;
        int cx;
        int cy;
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        cur_x    = '0;
        cur_y    = '0;
        dest_x   = '0;
        dest_y   = '0;
        in_port  = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        repeat (16) idle_cycle();  // quiet pipeline after reset

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if (i % 8 == 0) begin
                move_router_random();
            end
            pick_dest(dx, dy);
            send_request("random_pairs", dx, dy);
        end

        // one request per cycle from a single router
        move_router_random();
        for (int i = 0; i < BURST_COUNT; i++) begin
            pick_dest(dx, dy);
            send_request("back_to_back", dx, dy);
        end

        for (int i = 0; i < LOCAL_COUNT; i++) begin
            move_router_random();
            send_request("local_eject", router_x, router_y);
        end

        for (int i = 0; i < GAP_COUNT; i++) begin
            gap = $urandom_range(3, 0);
            if (gap > 0) begin
                repeat (gap - 1) idle_cycle();
                move_router_random();
            end
            pick_dest(dx, dy);
            send_request("idle_gaps", dx, dy);
        end

        // moves along the mesh border, where a wrap would show
        for (int corner = 0; corner < 4; corner++) begin
            cx = (corner % 2 == 1) ? MESH_NX - 1 : 0;
            cy = (corner / 2 == 1) ? MESH_NY - 1 : 0;
            move_router(cx, cy);
            for (int x = 0; x < MESH_NX; x++) begin
                for (int y = 0; y < MESH_NY; y++) begin
                    if (((x == cx) != (y == cy)) && xy_route(cx, cy, x, y) != SW_LOC) begin
                        send_request("mesh_corners", x, y);
                    end
                end
            end
        end

        idle_cycle();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // a stray out_valid would still be caught here
        if (recv_count != sent_count) begin
            other_count++;
            $display("ERROR: %0d requests were sent but %0d results came out",
                     sent_count, recv_count);
        end
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        other_count++;
        $display("ERROR: watchdog expired after %0d cycles with %0d results still pending",
                 WATCHDOG_CYCLES, exp_q.size());
        print_summary();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- build.f
+incdir+testbench
source/noc_route_pkg.sv
source/route_input_stage.sv
source/next_hop_predictor.sv
source/lookahead_port_stage.sv
source/lookahead_route_top.sv
testbench/tb_lookahead_route.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the look-ahead route testbench with Verilator.
# The exit status is nonzero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lookahead_route \
    -f build.f \
    --Mdir obj_dir \
    -o sim_lookahead_route

./obj_dir/sim_lookahead_route | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
